// ==== io_pkg.sv ====
`default_nettype none

package io_pkg;

    // display geometry
    localparam int digit_cnt         = 8;
    localparam int overflow_cnt      = 1;
    localparam int digit_radix_width = 4;
    localparam int digit_cnt_width   = 3;
    localparam int segment_cnt       = 8;

    localparam int switch_cnt  = 8;
    localparam int value_width = 32;

    localparam int key_rows = 4;
    localparam int key_cols = 4;

    // codes 0 to 9 are the decimal digits themselves
    typedef logic [3:0] key_code_t;

    localparam key_code_t key_backspace = 4'd10;
    localparam key_code_t key_clear     = 4'd11;
    localparam key_code_t key_confirm   = 4'd12;
    localparam key_code_t key_mode      = 4'd13;
    // the star and hash keys have codes but no function in the entry logic
    localparam key_code_t key_star      = 4'd14;
    localparam key_code_t key_hash      = 4'd15;

    typedef struct packed {
        logic      valid;
        key_code_t code;
    } key_event_t;

    // slot 0 is the leftmost tube, the hidden overflow slots sit above the displayed ones
    typedef struct packed {
        logic [(digit_cnt + overflow_cnt) * digit_radix_width - 1:0] digits;
        logic [3:0]                                                  count;
    } digit_buffer_t;

    typedef struct packed {
        logic                   valid;
        logic                   overflow;
        logic [value_width-1:0] value;
    } entry_result_t;

endpackage

`default_nettype wire

// ==== keypad_scanner.sv ====
`timescale 1ns/1ps
`default_nettype none

module keypad_scanner #(
    parameter int scan_cycles    = 2500,
    parameter int debounce_scans = 8
) (
    input  wire logic                        clk_tube,
    input  wire logic                        rst_n,
    input  wire logic [io_pkg::key_rows-1:0] key_row,
    output logic      [io_pkg::key_cols-1:0] key_col,
    output io_pkg::key_event_t               key_event
);
    import io_pkg::*;

    localparam int col_w = $clog2(key_cols);
    localparam int row_w = $clog2(key_rows);
    localparam int cyc_w = (scan_cycles > 1) ? $clog2(scan_cycles) : 1;
    localparam int run_w = $clog2(debounce_scans + 1);

    // telephone layout, row 0 on top
    localparam key_code_t key_map [key_rows][key_cols] = '{
        '{4'd1,     4'd2, 4'd3,     key_backspace},
        '{4'd4,     4'd5, 4'd6,     key_clear},
        '{4'd7,     4'd8, 4'd9,     key_confirm},
        '{key_star, 4'd0, key_hash, key_mode}
    };

    logic [cyc_w-1:0]    cyc_cnt;
    logic [col_w-1:0]    col_idx;
    logic                slot_end;
    logic                sweep_end;
    logic [key_rows-1:0] rows_hit;
    logic                col_one;
    logic                col_many;
    logic [row_w-1:0]    col_row;

    logic             acc_found;
    logic             acc_multi;
    logic [row_w-1:0] acc_row;
    logic [col_w-1:0] acc_col;
    logic             nxt_found;
    logic             nxt_multi;
    logic [row_w-1:0] nxt_row;
    logic [col_w-1:0] nxt_col;
    logic             sweep_hit;

    logic             last_hit;
    logic [row_w-1:0] last_row;
    logic [col_w-1:0] last_col;
    logic [run_w-1:0] run_cnt;
    logic [run_w-1:0] run_next;
    logic             same;
    logic             stable;
    logic             pressed;

    assign key_col   = ~(key_cols'(1) << col_idx);
    assign slot_end  = (cyc_cnt == cyc_w'(scan_cycles - 1));
    assign sweep_end = slot_end && (col_idx == col_w'(key_cols - 1));

    // rows are pulled up, a pressed key pulls its row low
    assign rows_hit = ~key_row;
    assign col_many = (rows_hit & (rows_hit - 1'b1)) != '0;
    assign col_one  = (rows_hit != '0) && !col_many;

    always_comb begin
        col_row = '0;
        for (int r = 0; r < key_rows; r++) begin
            if (rows_hit[r]) begin
                col_row = row_w'(r);
            end
        end
    end

    // fold the current column into this sweep, more than one key makes the sweep empty
    always_comb begin
        nxt_found = acc_found | (rows_hit != '0);
        nxt_multi = acc_multi | col_many | (acc_found & (rows_hit != '0));
        nxt_row   = acc_row;
        nxt_col   = acc_col;
        if (col_one && !acc_found) begin
            nxt_row = col_row;
            nxt_col = col_idx;
        end
        sweep_hit = nxt_found & ~nxt_multi;
        same = (sweep_hit == last_hit) &&
               (!sweep_hit || (nxt_row == last_row && nxt_col == last_col));
        if (!same) begin
            run_next = run_w'(1);
        end else if (run_cnt == run_w'(debounce_scans)) begin
            run_next = run_cnt;
        end else begin
            run_next = run_cnt + 1'b1;
        end
        stable = (run_next == run_w'(debounce_scans));
    end

    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            cyc_cnt   <= '0;
            col_idx   <= '0;
            acc_found <= 1'b0;
            acc_multi <= 1'b0;
            acc_row   <= '0;
            acc_col   <= '0;
        end else if (slot_end) begin
            cyc_cnt <= '0;
            if (sweep_end) begin
                col_idx   <= '0;
                acc_found <= 1'b0;
                acc_multi <= 1'b0;
            end else begin
                col_idx   <= col_idx + 1'b1;
                acc_found <= nxt_found;
                acc_multi <= nxt_multi;
                acc_row   <= nxt_row;
                acc_col   <= nxt_col;
            end
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
        end
    end

    // a press is reported once, when the pressed flag rises after a stable release
    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            last_hit  <= 1'b0;
            last_row  <= '0;
            last_col  <= '0;
            run_cnt   <= '0;
            pressed   <= 1'b0;
            key_event <= '0;
        end else begin
            key_event.valid <= 1'b0;
            if (sweep_end) begin
                last_hit <= sweep_hit;
                last_row <= nxt_row;
                last_col <= nxt_col;
                run_cnt  <= run_next;
                if (stable) begin
                    pressed <= sweep_hit;
                    if (sweep_hit && !pressed) begin
                        key_event.valid <= 1'b1;
                        key_event.code  <= key_map[nxt_row][nxt_col];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== digit_entry.sv ====
`timescale 1ns/1ps
`default_nettype none

module digit_entry (
    input  wire logic               clk_tube,
    input  wire logic               rst_n,
    input  wire logic               input_request,
    input  wire io_pkg::key_event_t key_event,
    output io_pkg::digit_buffer_t   digits,
    output logic                    switch_mode,
    output io_pkg::entry_result_t   result
);
    import io_pkg::*;

    localparam int slot_cnt     = digit_cnt + overflow_cnt;
    localparam int buf_width    = slot_cnt * digit_radix_width;
    localparam int hidden_width = overflow_cnt * digit_radix_width;
    localparam int w            = digit_radix_width;

    logic [value_width-1:0] value_calc;
    logic                   hidden_used;
    logic                   is_digit;

    // new digit enters on the right, slot 0 moves into the hidden slots
    function automatic digit_buffer_t push_digit(digit_buffer_t cur, key_code_t code);
        digit_buffer_t nxt;
        nxt = cur;
        for (int j = overflow_cnt - 1; j > 0; j--) begin
            nxt.digits[(digit_cnt + j) * w +: w] = cur.digits[(digit_cnt + j - 1) * w +: w];
        end
        nxt.digits[digit_cnt * w +: w] = cur.digits[0 +: w];
        for (int i = 0; i < digit_cnt - 1; i++) begin
            nxt.digits[i * w +: w] = cur.digits[(i + 1) * w +: w];
        end
        nxt.digits[(digit_cnt - 1) * w +: w] = w'(code);
        if (cur.count < 4'(slot_cnt)) begin
            nxt.count = cur.count + 1'b1;
        end
        return nxt;
    endfunction

    // exact inverse of push_digit, the topmost hidden slot refills with zero
    function automatic digit_buffer_t pop_digit(digit_buffer_t cur);
        digit_buffer_t nxt;
        nxt = cur;
        for (int i = digit_cnt - 1; i > 0; i--) begin
            nxt.digits[i * w +: w] = cur.digits[(i - 1) * w +: w];
        end
        nxt.digits[0 +: w] = cur.digits[digit_cnt * w +: w];
        for (int j = 0; j < overflow_cnt - 1; j++) begin
            nxt.digits[(digit_cnt + j) * w +: w] = cur.digits[(digit_cnt + j + 1) * w +: w];
        end
        nxt.digits[(slot_cnt - 1) * w +: w] = '0;
        nxt.count = cur.count - 1'b1;
        return nxt;
    endfunction

    assign hidden_used = digits.digits[buf_width-1 -: hidden_width] != '0;
    assign is_digit    = key_event.code <= 4'd9;

    // decimal to binary over the displayed slots, most significant first
    always_comb begin
        value_calc = '0;
        for (int i = 0; i < digit_cnt; i++) begin
            value_calc = value_calc * value_width'(10) + value_width'(digits.digits[i * w +: w]);
        end
    end

    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            digits      <= '0;
            switch_mode <= 1'b0;
            result      <= '0;
        end else begin
            result.valid <= 1'b0;
            if (input_request && key_event.valid) begin
                if (is_digit) begin
                    // once the hidden slot holds a real digit the entry is frozen
                    if (!hidden_used) begin
                        digits <= push_digit(digits, key_event.code);
                    end
                end else begin
                    case (key_event.code)
                        key_backspace: begin
                            if (digits.count != '0) begin
                                digits <= pop_digit(digits);
                            end
                        end
                        key_clear: begin
                            digits <= '0;
                        end
                        key_confirm: begin
                            result.valid    <= 1'b1;
                            result.overflow <= hidden_used;
                            result.value    <= value_calc;
                            digits          <= '0;
                        end
                        key_mode: begin
                            switch_mode <= ~switch_mode;
                        end
                        default: begin
                            // star and hash do nothing here
                        end
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== seven_seg_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module seven_seg_unit (
    input  wire logic                          clk_tube,
    input  wire logic                          rst_n,
    input  wire logic                          input_request,
    input  wire logic                          switch_mode,
    input  wire io_pkg::digit_buffer_t         digits,
    input  wire logic [io_pkg::switch_cnt-1:0] switch_map,
    output logic      [io_pkg::segment_cnt-1:0] seg_tube,
    output logic      [io_pkg::digit_cnt-1:0]   seg_enable
);
    import io_pkg::*;

    localparam int w = digit_radix_width;

    logic [digit_cnt_width-1:0] scan_idx;
    logic [w-1:0]               shown_digit;
    logic [w-1:0]               next_digit;
    logic [digit_cnt-1:0]       next_enable;
    logic [digit_cnt-1:0]       lead_zero;
    logic                       mode_q;

    // lead_zero[i] is set while slot i and every slot left of it are zero
    always_comb begin
        lead_zero[0] = digits.digits[0 +: w] == '0;
        for (int i = 1; i < digit_cnt; i++) begin
            lead_zero[i] = lead_zero[i-1] && (digits.digits[i * w +: w] == '0);
        end
    end

    always_comb begin
        if (switch_mode) begin
            next_digit = w'(switch_map[scan_idx]);
        end else begin
            next_digit = digits.digits[scan_idx * w +: w];
        end
        next_enable = '1;
        // a mode change blanks one scan step so no tube shows a mixed frame
        if (input_request && (switch_mode == mode_q) &&
            (switch_mode || !lead_zero[scan_idx])) begin
            next_enable[scan_idx] = 1'b0;
        end
    end

    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            scan_idx    <= '0;
            shown_digit <= '0;
            seg_enable  <= '1;
            mode_q      <= 1'b0;
        end else begin
            if (scan_idx == digit_cnt_width'(digit_cnt - 1)) begin
                scan_idx <= '0;
            end else begin
                scan_idx <= scan_idx + 1'b1;
            end
            shown_digit <= next_digit;
            seg_enable  <= next_enable;
            mode_q      <= switch_mode;
        end
    end

    // segment order is dp g f e d c b a, low lights the segment
    always_comb begin
        case (shown_digit)
            4'd0:    seg_tube = 8'b1100_0000;
            4'd1:    seg_tube = 8'b1111_1001;
            4'd2:    seg_tube = 8'b1010_0100;
            4'd3:    seg_tube = 8'b1011_0000;
            4'd4:    seg_tube = 8'b1001_1001;
            4'd5:    seg_tube = 8'b1001_0010;
            4'd6:    seg_tube = 8'b1000_0010;
            4'd7:    seg_tube = 8'b1111_1000;
            4'd8:    seg_tube = 8'b1000_0000;
            4'd9:    seg_tube = 8'b1001_0000;
            default: seg_tube = 8'b0000_0000;
        endcase
    end

endmodule

`default_nettype wire

// ==== input_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module input_top #(
    parameter int scan_cycles    = 2500,
    parameter int debounce_scans = 8
) (
    input  wire logic                           clk_tube,
    input  wire logic                           rst_n,
    input  wire logic                           input_request,
    input  wire logic [io_pkg::key_rows-1:0]    key_row,
    input  wire logic [io_pkg::switch_cnt-1:0]  switch_map,
    output logic      [io_pkg::key_cols-1:0]    key_col,
    output logic      [io_pkg::segment_cnt-1:0] seg_tube,
    output logic      [io_pkg::digit_cnt-1:0]   seg_enable,
    output logic                                result_valid,
    output logic                                result_overflow,
    output logic      [io_pkg::value_width-1:0] result_value
);
    import io_pkg::*;

    key_event_t    key_event;
    digit_buffer_t digits;
    logic          switch_mode;
    entry_result_t result;

    keypad_scanner #(
        .scan_cycles    (scan_cycles),
        .debounce_scans (debounce_scans)
    ) scanner0 (
        .clk_tube  (clk_tube),
        .rst_n     (rst_n),
        .key_row   (key_row),
        .key_col   (key_col),
        .key_event (key_event)
    );

    digit_entry entry0 (
        .clk_tube      (clk_tube),
        .rst_n         (rst_n),
        .input_request (input_request),
        .key_event     (key_event),
        .digits        (digits),
        .switch_mode   (switch_mode),
        .result        (result)
    );

    seven_seg_unit display0 (
        .clk_tube      (clk_tube),
        .rst_n         (rst_n),
        .input_request (input_request),
        .switch_mode   (switch_mode),
        .digits        (digits),
        .switch_map    (switch_map),
        .seg_tube      (seg_tube),
        .seg_enable    (seg_enable)
    );

    assign result_valid    = result.valid;
    assign result_overflow = result.overflow;
    assign result_value    = result.value;

endmodule

`default_nettype wire

// ==== input_top_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module input_top_checker (
    input wire logic                         clk_tube,
    input wire logic                         rst_n,
    input wire logic                         input_request,
    input wire logic                         result_valid,
    input wire logic [io_pkg::digit_cnt-1:0] seg_enable
);
    import io_pkg::*;

    // at most one tube is driven at any time
    one_tube_lit: assert property (
        @(posedge clk_tube) disable iff (!rst_n) $countones(~seg_enable) <= 1
    ) else $error("more than one tube enabled");

    result_pulse: assert property (
        @(posedge clk_tube) disable iff (!rst_n) result_valid |=> !result_valid
    ) else $error("result strobe longer than one cycle");

    // the display goes dark one cycle after the request drops
    dark_without_request: assert property (
        @(posedge clk_tube) disable iff (!rst_n) !$past(input_request) |-> seg_enable == '1
    ) else $error("display lit while input request was low");

endmodule

bind input_top input_top_checker chk0 (
    .clk_tube      (clk_tube),
    .rst_n         (rst_n),
    .input_request (input_request),
    .result_valid  (result.valid),
    .seg_enable    (seg_enable)
);

`default_nettype wire

// ==== tb_input_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_input_top;
    import io_pkg::*;

    localparam int scan_cycles    = 4;
    localparam int debounce_scans = 3;
    // a press or release is held long enough for the slowest debounce case
    localparam int settle_cycles  = (debounce_scans + 2) * scan_cycles * key_cols;
    localparam int press_cycles   = 2 * settle_cycles;
    localparam int press_budget   = 100;
    localparam int cycle_limit    = press_budget * press_cycles + 40 * digit_cnt + 200;

    logic                   clk_tube;
    logic                   rst_n;
    logic                   input_request;
    logic [key_rows-1:0]    key_row;
    logic [switch_cnt-1:0]  switch_map;
    logic [key_cols-1:0]    key_col;
    logic [segment_cnt-1:0] seg_tube;
    logic [digit_cnt-1:0]   seg_enable;
    logic                   result_valid;
    logic                   result_overflow;
    logic [value_width-1:0] result_value;

    logic       press_active;
    logic [1:0] press_row;
    logic [1:0] press_col;

    int         errors;
    int         test_start_errors;
    int         tests_run;
    int         strobes;
    int         cycles;
    logic [31:0] lcg_state;

    // expected state of the entry
    int         exp_slot[digit_cnt + overflow_cnt];
    int         exp_count;
    bit         exp_mode;
    int         exp_value_q[$];
    bit         exp_ovf_q[$];

    // physical keypad layout of the board with row 0 on top
    int key_layout[key_rows][key_cols] = '{
        '{1,  2, 3,  10},
        '{4,  5, 6,  11},
        '{7,  8, 9,  12},
        '{14, 0, 15, 13}
    };

    input_top #(
        .scan_cycles    (scan_cycles),
        .debounce_scans (debounce_scans)
    ) dut0 (
        .clk_tube        (clk_tube),
        .rst_n           (rst_n),
        .input_request   (input_request),
        .key_row         (key_row),
        .switch_map      (switch_map),
        .key_col         (key_col),
        .seg_tube        (seg_tube),
        .seg_enable      (seg_enable),
        .result_valid    (result_valid),
        .result_overflow (result_overflow),
        .result_value    (result_value)
    );

    initial begin
        clk_tube = 1'b0;
        forever #50 clk_tube = ~clk_tube;
    end

    // the pressed key shorts its row to the active low column
    always_comb begin
        key_row = '1;
        if (press_active && !key_col[press_col]) begin
            key_row[press_row] = 1'b0;
        end
    end

    function automatic int lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]);
    endfunction

    // segments run dp g f e d c b a and a lit segment is driven low
    function automatic logic [7:0] digit_segments(int d);
        logic [6:0] on_mask;
        case (d)
            0: on_mask = 7'b0111111;
            1: on_mask = 7'b0000110;
            2: on_mask = 7'b1011011;
            3: on_mask = 7'b1001111;
            4: on_mask = 7'b1100110;
            5: on_mask = 7'b1101101;
            6: on_mask = 7'b1111101;
            7: on_mask = 7'b0000111;
            8: on_mask = 7'b1111111;
            9: on_mask = 7'b1101111;
            default: return 8'h00;
        endcase
        return {1'b1, ~on_mask};
    endfunction

    // reference model of the entry rules for one accepted key
    function automatic void model_key(int code);
        int val;
        if (code <= 9) begin
            if (exp_slot[digit_cnt] == 0) begin
                exp_slot[digit_cnt] = exp_slot[0];
                for (int i = 0; i < digit_cnt - 1; i++) begin
                    exp_slot[i] = exp_slot[i + 1];
                end
                exp_slot[digit_cnt - 1] = code;
                if (exp_count < digit_cnt + overflow_cnt) begin
                    exp_count++;
                end
            end
        end else if (code == 10) begin
            if (exp_count != 0) begin
                for (int i = digit_cnt - 1; i > 0; i--) begin
                    exp_slot[i] = exp_slot[i - 1];
                end
                exp_slot[0] = exp_slot[digit_cnt];
                exp_slot[digit_cnt] = 0;
                exp_count--;
            end
        end else if (code == 11 || code == 12) begin
            if (code == 12) begin
                val = 0;
                for (int i = 0; i < digit_cnt; i++) begin
                    val = val * 10 + exp_slot[i];
                end
                exp_value_q.push_back(val);
                exp_ovf_q.push_back(exp_slot[digit_cnt] != 0);
            end
            foreach (exp_slot[i]) exp_slot[i] = 0;
            exp_count = 0;
        end else if (code == 13) begin
            exp_mode = !exp_mode;
        end
    endfunction

    function automatic bit expected_lit(int k);
        bit any;
        any = 0;
        for (int j = 0; j <= k; j++) begin
            if (exp_slot[j] != 0) any = 1;
        end
        if (!input_request) return 0;
        if (exp_mode) return 1;
        return any;
    endfunction

    task automatic press_key(int code);
        int r;
        int c;
        r = 0;
        c = 0;
        for (int i = 0; i < key_rows; i++) begin
            for (int j = 0; j < key_cols; j++) begin
                if (key_layout[i][j] == code) begin
                    r = i;
                    c = j;
                end
            end
        end
        if (input_request) model_key(code);
        @(posedge clk_tube);
        press_row    <= 2'(r);
        press_col    <= 2'(c);
        press_active <= 1'b1;
        repeat (settle_cycles) @(posedge clk_tube);
        press_active <= 1'b0;
        repeat (settle_cycles) @(posedge clk_tube);
    endtask

    task automatic confirm_entry();
        press_key(12);
        if (exp_value_q.size() != 0) begin
            $display("confirm at t=%0t produced no result strobe", $time);
            errors++;
            exp_value_q.delete();
            exp_ovf_q.delete();
        end
    endtask

    // one full scan window shows each tube exactly once
    task automatic check_display(string label);
        bit         lit[digit_cnt];
        logic [7:0] seen[digit_cnt];
        logic [7:0] exp_seg;
        foreach (lit[k]) lit[k] = 0;
        repeat (digit_cnt) begin
            @(negedge clk_tube);
            for (int k = 0; k < digit_cnt; k++) begin
                if (!seg_enable[k]) begin
                    lit[k]  = 1;
                    seen[k] = seg_tube;
                end
            end
        end
        for (int k = 0; k < digit_cnt; k++) begin
            if (lit[k] != expected_lit(k)) begin
                $display("ERROR t=%0t %s seg_enable[%0d]: expected %0d, got %0d", $time, label,
                         k, !expected_lit(k), !lit[k]);
                errors++;
            end else if (lit[k]) begin
                exp_seg = exp_mode ? digit_segments(int'(switch_map[k]))
                                   : digit_segments(exp_slot[k]);
                if (seen[k] !== exp_seg) begin
                    $display("ERROR t=%0t %s seg_tube[%0d]: expected %h, got %h", $time, label,
                             k, exp_seg, seen[k]);
                    errors++;
                end
            end
        end
    endtask

    task automatic end_test(string name);
        tests_run++;
        $display("%s: %s with %0d errors", name,
                 (errors == test_start_errors) ? "passed" : "failed", errors - test_start_errors);
        test_start_errors = errors;
    endtask

    // result strobes are compared against the values queued by the model
    always @(negedge clk_tube) begin
        if (rst_n && result_valid) begin
            strobes++;
            if (exp_value_q.size() == 0) begin
                $display("unexpected result strobe at t=%0t", $time);
                errors++;
            end else begin
                if (result_value !== 32'(exp_value_q[0])) begin
                    $display("ERROR t=%0t result_value: expected %0d, got %0d", $time,
                             exp_value_q[0], result_value);
                    errors++;
                end
                if (result_overflow !== exp_ovf_q[0]) begin
                    $display("ERROR t=%0t result_overflow: expected %0d, got %0d", $time,
                             exp_ovf_q[0], result_overflow);
                    errors++;
                end
                void'(exp_value_q.pop_front());
                void'(exp_ovf_q.pop_front());
            end
        end
    end

    always @(posedge clk_tube) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("the run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        int len;
        rst_n         = 1'b0;
        input_request = 1'b0;
        switch_map    = '0;
        press_active  = 1'b0;
        press_row     = '0;
        press_col     = '0;
        errors = 0;
        test_start_errors = 0;
        tests_run = 0;
        strobes = 0;
        cycles = 0;
        lcg_state = 32'd41;
        foreach (exp_slot[i]) exp_slot[i] = 0;
        exp_count = 0;
        exp_mode  = 0;

        repeat (10) @(posedge clk_tube);
        @(negedge clk_tube);
        if (key_col !== 4'b1110) begin
            $display("ERROR t=%0t key_col: expected 1110, got %b", $time, key_col);
            errors++;
        end
        if (seg_enable !== '1) begin
            $display("ERROR t=%0t seg_enable: expected ff, got %h", $time, seg_enable);
            errors++;
        end
        if (result_valid !== 1'b0) begin
            $display("ERROR t=%0t result_valid: expected 0, got %b", $time, result_valid);
            errors++;
        end
        @(posedge clk_tube);
        rst_n         <= 1'b1;
        input_request <= 1'b1;
        repeat (4) @(posedge clk_tube);
        check_display("reset");
        end_test("reset state");

        for (int round = 0; round < 4; round++) begin
            len = lcg_next() % digit_cnt + 1;
            repeat (len) press_key(lcg_next() % 10);
            check_display("digits");
            confirm_entry();
            check_display("after confirm");
        end
        end_test("random entries");

        press_key(3);
        press_key(0);
        press_key(7);
        press_key(5);
        press_key(10);
        check_display("backspace");
        press_key(10);
        check_display("backspace");
        press_key(11);
        check_display("clear");
        press_key(0);
        press_key(0);
        check_display("zero entry");
        confirm_entry();
        end_test("edit keys");

        press_key(lcg_next() % 9 + 1);
        repeat (digit_cnt) press_key(lcg_next() % 10);
        check_display("nine digits");
        press_key(4);
        press_key(6);
        check_display("ignored digits");
        confirm_entry();
        end_test("overflow");

        press_key(8);
        press_key(1);
        @(posedge clk_tube);
        switch_map <= switch_cnt'(lcg_next());
        press_key(13);
        check_display("switch mode");
        press_key(13);
        check_display("keypad mode");
        end_test("mode toggle");

        press_key(2);
        @(posedge clk_tube);
        input_request <= 1'b0;
        repeat (2) @(posedge clk_tube);
        check_display("request low");
        press_key(9);
        press_key(11);
        check_display("request low");
        @(posedge clk_tube);
        input_request <= 1'b1;
        repeat (2) @(posedge clk_tube);
        check_display("request high");
        confirm_entry();
        end_test("input request");

        if (exp_value_q.size() != 0) begin
            $display("%0d expected results were never strobed", exp_value_q.size());
            errors++;
        end
        $display("%0d tests run, %0d result strobes, %0d errors", tests_run, strobes, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
io_pkg.sv
keypad_scanner.sv
digit_entry.sv
seven_seg_unit.sv
input_top.sv
input_top_checker.sv
tb_input_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_input_top
FILELIST  := all.f
FLAGS     := --binary --timing --assert -Wno-fatal
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
